/* decode_ifs.sv */
// Decode stage interfaces between queue, decoder and issue buffer

// Head of the instruction queue as seen by the decoder
interface fetch_entry_if;
    import rv_isa_pkg::*;

    logic  valid;
    inst_t inst;
    xlen_t pc;
    logic  pop;

    modport queue_side (
        output valid,
        output inst,
        output pc,
        input  pop
    );

    modport decoder_side (
        input  valid,
        input  inst,
        input  pc,
        output pop
    );
endinterface

// Decoded bundle handed over to the issue buffer
interface issue_if;
    import rv_isa_pkg::*;

    logic      push;
    reg_addr_t rd_addr;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     pc;
    inst_t     inst;
    xlen_t     rs2_data;
    logic      has_space;

    modport decoder_side (
        output push,
        output rd_addr,
        output op1,
        output op2,
        output pc,
        output inst,
        output rs2_data,
        input  has_space
    );

    modport buffer_side (
        input  push,
        input  rd_addr,
        input  op1,
        input  op2,
        input  pc,
        input  inst,
        input  rs2_data,
        output has_space
    );
endinterface

/* decode_pkg.sv */
// Decode stage package with operand and redirect select codes, FSM states and defaults
package decode_pkg;

    // First ALU operand source
    typedef logic op1_sel_t;

    localparam op1_sel_t OP1_RS1   = 1'b0;
    localparam op1_sel_t OP1_IMM_U = 1'b1;

    // Second ALU operand source
    typedef logic [1:0] op2_sel_t;

    localparam op2_sel_t OP2_PC    = 2'b00;
    localparam op2_sel_t OP2_IMM_I = 2'b01;
    localparam op2_sel_t OP2_IMM_S = 2'b10;
    localparam op2_sel_t OP2_RS2   = 2'b11;

    // Next-pc kind reported to fetch
    typedef logic [1:0] pc_sel_t;

    localparam pc_sel_t PC_SEL_SEQ    = 2'b00;
    localparam pc_sel_t PC_SEL_JALR   = 2'b01;
    localparam pc_sel_t PC_SEL_BRANCH = 2'b10;
    localparam pc_sel_t PC_SEL_JAL    = 2'b11;

    // Decoder FSM
    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        DONE
    } dec_state_e;

    // Top-level defaults
    localparam int DEF_QUEUE_DEPTH   = 4;
    localparam int DEF_ISSUE_CREDITS = 2;

endpackage

/* decode_top.sv */
// Decode stage top level joining queue, decoder, register file and issue buffer
module decode_top #(
    parameter int QUEUE_DEPTH   = decode_pkg::DEF_QUEUE_DEPTH,
    parameter int ISSUE_CREDITS = decode_pkg::DEF_ISSUE_CREDITS
) (
    input  logic                  clk,
    input  logic                  rst,
    // Fetch side
    input  logic                  in_valid_i,
    input  rv_isa_pkg::inst_t     in_inst_i,
    input  rv_isa_pkg::xlen_t     in_pc_i,
    output logic                  in_credit_o,
    // Execute side
    input  logic                  out_credit_i,
    output logic                  out_valid_o,
    output rv_isa_pkg::reg_addr_t out_rd_o,
    output rv_isa_pkg::xlen_t     out_op1_o,
    output rv_isa_pkg::xlen_t     out_op2_o,
    output rv_isa_pkg::xlen_t     out_pc_o,
    output rv_isa_pkg::inst_t     out_inst_o,
    output rv_isa_pkg::xlen_t     out_rs2_data_o,
    // Redirect to fetch
    output logic                  redirect_valid_o,
    output decode_pkg::pc_sel_t   redirect_sel_o,
    output rv_isa_pkg::xlen_t     redirect_target_o,
    // Register write port
    input  logic                  wb_en_i,
    input  rv_isa_pkg::reg_addr_t wb_addr_i,
    input  rv_isa_pkg::xlen_t     wb_data_i
);
    import rv_isa_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    fetch_entry_if fetch_if ();
    issue_if       iss_if ();

    inst_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_inst_i   (in_inst_i),
        .in_pc_i     (in_pc_i),
        .in_credit_o (in_credit_o),
        .q_o         (fetch_if.queue_side)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_en_i    (wb_en_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    inst_decoder u_decoder (
        .clk               (clk),
        .rst               (rst),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .rs1_addr_o        (rs1_addr),
        .rs2_addr_o        (rs2_addr),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_sel_o    (redirect_sel_o),
        .redirect_target_o (redirect_target_o),
        .q_i               (fetch_if.decoder_side),
        .iss_o             (iss_if.decoder_side)
    );

    issue_buffer #(.CREDITS(ISSUE_CREDITS)) u_issue (
        .clk            (clk),
        .rst            (rst),
        .out_credit_i   (out_credit_i),
        .out_valid_o    (out_valid_o),
        .out_rd_o       (out_rd_o),
        .out_op1_o      (out_op1_o),
        .out_op2_o      (out_op2_o),
        .out_pc_o       (out_pc_o),
        .out_inst_o     (out_inst_o),
        .out_rs2_data_o (out_rs2_data_o),
        .iss_i          (iss_if.buffer_side)
    );

endmodule

/* files.f */
rv_isa_pkg.sv
decode_pkg.sv
decode_ifs.sv
inst_queue.sv
reg_file.sv
inst_decoder.sv
issue_buffer.sv
decode_top.sv
tb_decode_top.sv

/* inst_decoder.sv */
// Multicycle RV32I decoder with immediates, operand select and branch resolution
module inst_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_isa_pkg::xlen_t     rs1_data_i,
    input  rv_isa_pkg::xlen_t     rs2_data_i,
    output rv_isa_pkg::reg_addr_t rs1_addr_o,
    output rv_isa_pkg::reg_addr_t rs2_addr_o,
    output logic                  redirect_valid_o,
    output decode_pkg::pc_sel_t   redirect_sel_o,
    output rv_isa_pkg::xlen_t     redirect_target_o,
    fetch_entry_if.decoder_side   q_i,
    issue_if.decoder_side         iss_o
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    dec_state_e state_q;
    inst_t      inst_q;
    xlen_t      pc_q;

    // Results captured at the end of DECODE
    xlen_t   op1_q;
    xlen_t   op2_q;
    xlen_t   rs2_q;
    pc_sel_t sel_q;
    xlen_t   target_q;

    opcode_t  opcode;
    funct3_t  funct3;
    xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    op1_sel_t op1_sel;
    op2_sel_t op2_sel;
    logic     taken;
    pc_sel_t  pc_sel;
    xlen_t    op1, op2, target;

    // Accept only if the bundle will find room downstream
    assign q_i.pop = (state_q == IDLE) && q_i.valid && iss_o.has_space;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            inst_q  <= '0;
            pc_q    <= RESET_PC;
        end else begin
            case (state_q)
                IDLE: begin
                    if (q_i.pop) begin
                        inst_q  <= q_i.inst;
                        pc_q    <= q_i.pc;
                        state_q <= DECODE;
                    end
                end
                DECODE:  state_q <= DONE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DECODE) begin
            op1_q    <= op1;
            op2_q    <= op2;
            rs2_q    <= rs2_data_i;
            sel_q    <= pc_sel;
            target_q <= target;
        end
    end

    assign opcode     = inst_q[6:0];
    assign funct3     = inst_q[14:12];
    assign rs1_addr_o = inst_q[19:15];
    assign rs2_addr_o = inst_q[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_u = {inst_q[31:12], 12'b0};
    assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

    always_comb begin
        op1_sel = OP1_RS1;
        op2_sel = OP2_PC;
        case (opcode)
            OPC_LUI, OPC_AUIPC:  op1_sel = OP1_IMM_U;
            OPC_LOAD, OPC_OP_IMM: op2_sel = OP2_IMM_I;
            OPC_STORE:           op2_sel = OP2_IMM_S;
            OPC_OP:              op2_sel = OP2_RS2;
            // Jumps, branches and illegal opcodes keep rs1 and pc
            default: ;
        endcase
    end

    assign op1 = (op1_sel == OP1_IMM_U) ? imm_u : rs1_data_i;

    always_comb begin
        case (op2_sel)
            OP2_IMM_I: op2 = imm_i;
            OP2_IMM_S: op2 = imm_s;
            OP2_RS2:   op2 = rs2_data_i;
            default:   op2 = pc_q;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (rs1_data_i == rs2_data_i);
            F3_BNE:  taken = (rs1_data_i != rs2_data_i);
            F3_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            F3_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            F3_BLTU: taken = (rs1_data_i < rs2_data_i);
            F3_BGEU: taken = (rs1_data_i >= rs2_data_i);
            default: taken = 1'b0;
        endcase
    end

    // Redirect kind and its target
    always_comb begin
        if (opcode == OPC_JALR && funct3 == F3_JALR) begin
            pc_sel = PC_SEL_JALR;
            target = rs1_data_i + imm_i;
        end else if (opcode == OPC_JAL) begin
            pc_sel = PC_SEL_JAL;
            target = pc_q + imm_j;
        end else if (opcode == OPC_BRANCH && taken) begin
            pc_sel = PC_SEL_BRANCH;
            target = pc_q + imm_b;
        end else begin
            pc_sel = PC_SEL_SEQ;
            target = pc_q + 32'd4;
        end
    end

    assign redirect_valid_o  = (state_q == DONE);
    assign redirect_sel_o    = sel_q;
    assign redirect_target_o = target_q;

    // Bundle to the issue buffer
    assign iss_o.push     = (state_q == DONE);
    assign iss_o.rd_addr  = inst_q[11:7];
    assign iss_o.op1      = op1_q;
    assign iss_o.op2      = op2_q;
    assign iss_o.pc       = pc_q;
    assign iss_o.inst     = inst_q;
    assign iss_o.rs2_data = rs2_q;

endmodule

/* inst_queue.sv */
// Instruction queue, a credit-fed FIFO of instruction and pc pairs
module inst_queue #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid_i,
    input  rv_isa_pkg::inst_t    in_inst_i,
    input  rv_isa_pkg::xlen_t    in_pc_i,
    output logic                 in_credit_o,
    fetch_entry_if.queue_side    q_o
);
    import rv_isa_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    inst_t inst_mem [DEPTH];
    xlen_t pc_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;
    logic             credit_q;

    assign do_pop = q_o.valid && q_o.pop;

    // Head entry
    assign q_o.valid = (count != '0);
    assign q_o.inst  = inst_mem[rd_ptr];
    assign q_o.pc    = pc_mem[rd_ptr];

    assign in_credit_o = credit_q;

    // Upstream never writes without a credit
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            inst_mem[wr_ptr] <= in_inst_i;
            pc_mem[wr_ptr]   <= in_pc_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (in_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per consumed entry
            credit_q <= do_pop;
        end
    end

endmodule

/* issue_buffer.sv */
// Two-entry issue buffer that drains toward execute under credit control
module issue_buffer #(
    parameter int CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  out_credit_i,
    output logic                  out_valid_o,
    output rv_isa_pkg::reg_addr_t out_rd_o,
    output rv_isa_pkg::xlen_t     out_op1_o,
    output rv_isa_pkg::xlen_t     out_op2_o,
    output rv_isa_pkg::xlen_t     out_pc_o,
    output rv_isa_pkg::inst_t     out_inst_o,
    output rv_isa_pkg::xlen_t     out_rs2_data_o,
    issue_if.buffer_side          iss_i
);
    import rv_isa_pkg::*;

    localparam int CRED_W = $clog2(CREDITS + 1);

    reg_addr_t rd_mem  [2];
    xlen_t     op1_mem [2];
    xlen_t     op2_mem [2];
    xlen_t     pc_mem  [2];
    inst_t     inst_mem[2];
    xlen_t     rs2_mem [2];

    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic [CRED_W-1:0] credits;
    logic              send;

    assign send            = (count != 2'd0) && (credits != '0);
    assign iss_i.has_space = (count != 2'd2);

    always_ff @(posedge clk) begin
        if (iss_i.push) begin
            rd_mem[wr_ptr]   <= iss_i.rd_addr;
            op1_mem[wr_ptr]  <= iss_i.op1;
            op2_mem[wr_ptr]  <= iss_i.op2;
            pc_mem[wr_ptr]   <= iss_i.pc;
            inst_mem[wr_ptr] <= iss_i.inst;
            rs2_mem[wr_ptr]  <= iss_i.rs2_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= 2'd0;
            credits <= CRED_W'(CREDITS);
        end else begin
            if (iss_i.push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (send) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({iss_i.push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Send and return together cancel out
            case ({send, out_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign out_valid_o    = send;
    assign out_rd_o       = rd_mem[rd_ptr];
    assign out_op1_o      = op1_mem[rd_ptr];
    assign out_op2_o      = op2_mem[rd_ptr];
    assign out_pc_o       = pc_mem[rd_ptr];
    assign out_inst_o     = inst_mem[rd_ptr];
    assign out_rs2_data_o = rs2_mem[rd_ptr];

endmodule

/* reg_file.sv */
// Integer register file with two combinational read ports and x0 tied to zero
module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t rs2_addr_i,
    input  logic                  wb_en_i,
    input  rv_isa_pkg::reg_addr_t wb_addr_i,
    input  rv_isa_pkg::xlen_t     wb_data_i,
    output rv_isa_pkg::xlen_t     rs1_data_o,
    output rv_isa_pkg::xlen_t     rs2_data_o
);
    import rv_isa_pkg::*;

    // Storage for x1 to x31 only
    xlen_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && (wb_addr_i != '0)) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal --top-module tb_decode_top -f files.f -o tb_sim &&
./obj_dir/tb_sim | tee sim.log
grep -qsx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* rv_isa_pkg.sv */
// RV32I ISA package with base widths, instruction field types and encodings
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            opcode_t;

    // Major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // JALR only defines one funct3
    localparam funct3_t F3_JALR = 3'b000;

    // Boot address
    localparam xlen_t RESET_PC = 32'h8000_0000;

endpackage

/* tb_decode_top.sv */
// Testbench for the decode stage, table driven with a reference model and credit loops
module tb_decode_top;
    import rv_isa_pkg::*;
    import decode_pkg::*;

    localparam int QUEUE_DEPTH    = DEF_QUEUE_DEPTH;
    localparam int ISSUE_CREDITS  = DEF_ISSUE_CREDITS;
    localparam int N_ROWS         = 32;
    localparam int HOLD_CYCLES    = 20;
    localparam int TIMEOUT_CYCLES = 40 * N_ROWS + 200;

    logic      clk;
    logic      rst;
    logic      in_valid_i;
    inst_t     in_inst_i;
    xlen_t     in_pc_i;
    logic      in_credit_o;
    logic      out_credit_i = 1'b0;
    logic      out_valid_o;
    reg_addr_t out_rd_o;
    xlen_t     out_op1_o;
    xlen_t     out_op2_o;
    xlen_t     out_pc_o;
    inst_t     out_inst_o;
    xlen_t     out_rs2_data_o;
    logic      redirect_valid_o;
    pc_sel_t   redirect_sel_o;
    xlen_t     redirect_target_o;
    logic      wb_en_i;
    reg_addr_t wb_addr_i;
    xlen_t     wb_data_i;

    // Stimulus table and expected results
    inst_t     row_inst [N_ROWS];
    xlen_t     row_pc   [N_ROWS];
    xlen_t     row_op1  [N_ROWS];
    xlen_t     row_op2  [N_ROWS];
    pc_sel_t   row_sel  [N_ROWS];
    xlen_t     row_tgt  [N_ROWS];
    reg_addr_t row_rd   [N_ROWS];
    xlen_t     row_rs2  [N_ROWS];

    // Register contents as loaded through the write port
    xlen_t rm [32];

    int     n_rows        = 0;
    int     sent          = 0;
    int     credits       = QUEUE_DEPTH;
    int     credit_pulses = 0;
    int     out_idx       = 0;
    int     redir_idx     = 0;
    int     sends         = 0;
    int     returns       = 0;
    int     gap           = 0;
    int     hold_cnt      = 0;
    logic   hold          = 1'b1;
    int     cycles        = 0;
    integer seed          = 32'hfa0f;

    decode_top #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .ISSUE_CREDITS (ISSUE_CREDITS)
    ) dut (
        .clk               (clk),
        .rst               (rst),
        .in_valid_i        (in_valid_i),
        .in_inst_i         (in_inst_i),
        .in_pc_i           (in_pc_i),
        .in_credit_o       (in_credit_o),
        .out_credit_i      (out_credit_i),
        .out_valid_o       (out_valid_o),
        .out_rd_o          (out_rd_o),
        .out_op1_o         (out_op1_o),
        .out_op2_o         (out_op2_o),
        .out_pc_o          (out_pc_o),
        .out_inst_o        (out_inst_o),
        .out_rs2_data_o    (out_rs2_data_o),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_sel_o    (redirect_sel_o),
        .redirect_target_o (redirect_target_o),
        .wb_en_i           (wb_en_i),
        .wb_addr_i         (wb_addr_i),
        .wb_data_i         (wb_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s at t=%0t", msg, $time);
        abort_run();
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("error t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc_sel(input string name, input pc_sel_t got, input pc_sel_t exp);
        if (got !== exp) begin
            $display("error t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Assemble one instruction word from its fields
    function automatic inst_t encode_inst(input opcode_t opc, input funct3_t f3,
                                          input reg_addr_t rd, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input int imm);
        logic [31:0] v;
        v = imm;
        case (opc)
            OPC_LUI, OPC_AUIPC: return {v[19:0], rd, opc};
            OPC_JAL:            return {v[20], v[10:1], v[11], v[19:12], rd, opc};
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return {v[11:0], rs1, f3, rd, opc};
            OPC_STORE:          return {v[11:5], rs2, rs1, f3, v[4:0], opc};
            OPC_BRANCH:         return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], opc};
            default:            return {7'b0, rs2, rs1, f3, rd, opc};
        endcase
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Reference model filling one table row with its expected results
    task automatic add_row(input opcode_t opc, input funct3_t f3, input reg_addr_t rd,
                           input reg_addr_t rs1, input reg_addr_t rs2, input int imm);
        inst_t w;
        xlen_t pc;
        xlen_t immx;
        w    = encode_inst(opc, f3, rd, rs1, rs2, imm);
        pc   = RESET_PC + xlen_t'(n_rows * 4);
        immx = imm;
        row_inst[n_rows] = w;
        row_pc[n_rows]   = pc;
        row_rd[n_rows]   = w[11:7];
        row_rs2[n_rows]  = rm[w[24:20]];
        if (opc == OPC_LUI || opc == OPC_AUIPC) begin
            row_op1[n_rows] = {immx[19:0], 12'b0};
        end else begin
            row_op1[n_rows] = rm[w[19:15]];
        end
        case (opc)
            OPC_LOAD, OPC_OP_IMM, OPC_STORE: row_op2[n_rows] = immx;
            OPC_OP:  row_op2[n_rows] = rm[w[24:20]];
            default: row_op2[n_rows] = pc;
        endcase
        row_sel[n_rows] = PC_SEL_SEQ;
        row_tgt[n_rows] = pc + 32'd4;
        if (opc == OPC_JALR) begin
            row_sel[n_rows] = PC_SEL_JALR;
            row_tgt[n_rows] = rm[rs1] + immx;
        end else if (opc == OPC_JAL) begin
            row_sel[n_rows] = PC_SEL_JAL;
            row_tgt[n_rows] = pc + immx;
        end else if (opc == OPC_BRANCH && branch_taken(f3, rm[rs1], rm[rs2])) begin
            row_sel[n_rows] = PC_SEL_BRANCH;
            row_tgt[n_rows] = pc + immx;
        end
        n_rows++;
    endtask

    task automatic write_reg(input reg_addr_t addr, input xlen_t data);
        @(negedge clk);
        wb_en_i   = 1'b1;
        wb_addr_i = addr;
        wb_data_i = data;
        if (addr != 5'd0) begin
            rm[addr] = data;
        end
    endtask

    task automatic build_table();
        add_row(OPC_OP, 3'b000, 5'd8, 5'd1, 5'd2, 0);
        add_row(OPC_OP, 3'b000, 5'd9, 5'd0, 5'd7, 0);
        add_row(OPC_OP, 3'b000, 5'd10, 5'd6, 5'd0, 0);
        add_row(OPC_OP_IMM, 3'b000, 5'd11, 5'd2, 5'd0, -12);
        add_row(OPC_OP_IMM, 3'b000, 5'd12, 5'd0, 5'd0, 2047);
        add_row(OPC_OP_IMM, 3'b000, 5'd13, 5'd7, 5'd0, -2048);
        add_row(OPC_LUI, 3'b000, 5'd14, 5'd0, 5'd0, 'hABCDE);
        add_row(OPC_AUIPC, 3'b000, 5'd15, 5'd0, 5'd0, 'h80000);
        add_row(OPC_LOAD, 3'b010, 5'd16, 5'd5, 5'd0, -4);
        add_row(OPC_LOAD, 3'b010, 5'd17, 5'd1, 5'd0, 40);
        add_row(OPC_STORE, 3'b010, 5'd0, 5'd5, 5'd7, -20);
        add_row(OPC_STORE, 3'b010, 5'd0, 5'd1, 5'd2, 100);
        // Each condition taken and not taken with signed and unsigned pairs
        add_row(OPC_BRANCH, F3_BEQ, 5'd0, 5'd1, 5'd3, 16);
        add_row(OPC_BRANCH, F3_BEQ, 5'd0, 5'd1, 5'd2, 16);
        add_row(OPC_BRANCH, F3_BNE, 5'd0, 5'd1, 5'd2, -8);
        add_row(OPC_BRANCH, F3_BNE, 5'd0, 5'd1, 5'd3, -8);
        add_row(OPC_BRANCH, F3_BLT, 5'd0, 5'd2, 5'd1, 64);
        add_row(OPC_BRANCH, F3_BLT, 5'd0, 5'd1, 5'd2, 64);
        add_row(OPC_BRANCH, F3_BGE, 5'd0, 5'd1, 5'd2, -64);
        add_row(OPC_BRANCH, F3_BGE, 5'd0, 5'd2, 5'd1, -64);
        add_row(OPC_BRANCH, F3_BLTU, 5'd0, 5'd1, 5'd2, 4094);
        add_row(OPC_BRANCH, F3_BLTU, 5'd0, 5'd2, 5'd1, 32);
        add_row(OPC_BRANCH, F3_BGEU, 5'd0, 5'd2, 5'd1, -4096);
        add_row(OPC_BRANCH, F3_BGEU, 5'd0, 5'd1, 5'd2, 32);
        add_row(OPC_BRANCH, F3_BLT, 5'd0, 5'd4, 5'd1, 128);
        add_row(OPC_BRANCH, F3_BLTU, 5'd0, 5'd4, 5'd1, 128);
        add_row(OPC_BRANCH, F3_BGE, 5'd0, 5'd3, 5'd1, 12);
        add_row(OPC_JAL, 3'b000, 5'd1, 5'd0, 5'd0, 2048);
        add_row(OPC_JAL, 3'b000, 5'd0, 5'd0, 5'd0, -1024);
        add_row(OPC_JALR, F3_JALR, 5'd1, 5'd5, 5'd0, -16);
        add_row(OPC_JALR, F3_JALR, 5'd0, 5'd7, 5'd0, 4);
        // Unknown opcode
        add_row(7'b1111111, 3'b000, 5'd3, 5'd6, 5'd2, 0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure("run timed out before all bundles came out");
        end
    end

    // Redirect pulses follow table order
    always @(negedge clk) begin
        if (redirect_valid_o) begin
            if (redir_idx >= N_ROWS) begin
                report_failure("redirect pulse seen after the last table row");
            end
            check_pc_sel("redirect_sel_o", redirect_sel_o, row_sel[redir_idx]);
            check_xlen("redirect_target_o", redirect_target_o, row_tgt[redir_idx]);
            redir_idx++;
        end
    end

    // Execute side checking bundles and returning credits
    always @(negedge clk) begin
        if (out_valid_o) begin
            if (sends - returns >= ISSUE_CREDITS) begin
                report_failure("out_valid_o high with no downstream credit left");
            end
            if (out_idx >= N_ROWS) begin
                report_failure("bundle seen after the last table row");
            end
            check_addr("out_rd_o", out_rd_o, row_rd[out_idx]);
            check_xlen("out_op1_o", out_op1_o, row_op1[out_idx]);
            check_xlen("out_op2_o", out_op2_o, row_op2[out_idx]);
            check_xlen("out_pc_o", out_pc_o, row_pc[out_idx]);
            check_xlen("out_inst_o", out_inst_o, row_inst[out_idx]);
            check_xlen("out_rs2_data_o", out_rs2_data_o, row_rs2[out_idx]);
            out_idx++;
            sends++;
        end
        out_credit_i = 1'b0;
        // Withhold credits for a while once the first ones are spent
        if (hold) begin
            if (sends >= ISSUE_CREDITS) begin
                hold_cnt++;
            end
            if (hold_cnt >= HOLD_CYCLES) begin
                hold = 1'b0;
            end
        end else if (sends > returns) begin
            if (gap == 0) begin
                out_credit_i = 1'b1;
                returns++;
                gap = $random(seed) & 3;
            end else begin
                gap--;
            end
        end
    end

    initial begin
        rst        = 1'b1;
        in_valid_i = 1'b0;
        in_inst_i  = '0;
        in_pc_i    = '0;
        wb_en_i    = 1'b0;
        wb_addr_i  = '0;
        wb_data_i  = '0;
        for (int i = 0; i < 32; i++) begin
            rm[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (in_credit_o || redirect_valid_o || out_valid_o) begin
            report_failure("outputs not low after reset");
        end

        write_reg(5'd0, 32'hDEAD_BEEF);
        write_reg(5'd1, 32'd5);
        write_reg(5'd2, 32'hFFFF_FFFD);
        write_reg(5'd3, 32'd5);
        write_reg(5'd4, 32'h8000_0000);
        write_reg(5'd5, 32'h0000_1000);
        write_reg(5'd6, 32'd7);
        write_reg(5'd7, 32'h1234_5678);
        @(negedge clk);
        wb_en_i = 1'b0;

        build_table();
        if (n_rows != N_ROWS) begin
            report_failure("stimulus table size does not match its declared length");
        end

        // Fetch side sending only while it holds a credit
        while (sent < N_ROWS || out_idx < N_ROWS || redir_idx < N_ROWS) begin
            @(negedge clk);
            if (in_credit_o) begin
                credits++;
                credit_pulses++;
            end
            if (credits > QUEUE_DEPTH) begin
                report_failure("more upstream credits returned than entries sent");
            end
            if (sent < N_ROWS && credits > 0) begin
                in_valid_i = 1'b1;
                in_inst_i  = row_inst[sent];
                in_pc_i    = row_pc[sent];
                sent++;
                credits--;
            end else begin
                in_valid_i = 1'b0;
            end
        end
        repeat (6) begin
            @(negedge clk);
            if (in_credit_o) begin
                credit_pulses++;
            end
        end

        if (credit_pulses == sent) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("error t=%0t in_credit_o pulses got=%0d exp=%0d", $time,
                     credit_pulses, sent);
            abort_run();
        end
    end

endmodule
